// File: verilog/ysyx_fetch_cfg_pkg.sv
// RV64 fetch widths are fixed and the SRAM word must stay exactly two instructions wide
package ysyx_fetch_cfg_pkg;

  // datapath widths
  localparam int unsigned PC_WD        = 64;
  localparam int unsigned SRAM_ADDR_WD = 64; // byte address, low 3 bits always zero
  localparam int unsigned SRAM_DATA_WD = 64;
  localparam int unsigned INST_WD      = 32; // no compressed instructions

  typedef logic [PC_WD-1:0] pc_t;

  // first fetched address after reset
  localparam pc_t PC_RESETVAL = 64'h0000_0000_8000_0000;

  // sequential increment, one 32-bit instruction
  localparam pc_t PC_STEP = 64'd4;

endpackage

// File: verilog/ysyx_fetch_inst_pkg.sv
// Instruction word views assume a little-endian SRAM so address+0 sits in the low half
package ysyx_fetch_inst_pkg;

  typedef logic [ysyx_fetch_cfg_pkg::INST_WD-1:0] inst_t;

  // hi is the instruction at pc with bit 2 set
  typedef struct packed {
    inst_t hi;
    inst_t lo;
  } sram_halves_t;

  // one SRAM word, seen as raw data or as two instructions
  typedef union packed {
    logic [ysyx_fetch_cfg_pkg::SRAM_DATA_WD-1:0] whole; // what the sram port carries
    sram_halves_t                                halves; // decoded view for the if stage
  } sram_word_u;

endpackage

// File: verilog/ysyx_fetch_pc.sv
// PC generator issues the SRAM read in the same cycle it loads and has no alignment checks on targets
module ysyx_fetch_pc (
  input  logic                                        i_clk,
  input  logic                                        i_rst_n,
  // load request from if stage
  input  logic                                        i_load,
  // redirect from decode
  input  logic                                        i_br_sel,
  input  ysyx_fetch_cfg_pkg::pc_t                     i_br_target,
  // current fetch pc
  output ysyx_fetch_cfg_pkg::pc_t                     o_pc,
  // inst sram read port
  output logic                                        o_inst_sram_ren,
  output logic [ysyx_fetch_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  import ysyx_fetch_cfg_pkg::*;

  pc_t pc_q;
  pc_t seq_pc;
  pc_t next_pc;

  assign seq_pc  = pc_q + PC_STEP;
  assign next_pc = i_br_sel ? i_br_target : seq_pc; // redirect wins over sequential

  // reset value sits one step behind so the first load fetches PC_RESETVAL
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= PC_RESETVAL - PC_STEP;
    end else if (i_load) begin
      pc_q <= next_pc;
    end
  end

  assign o_pc = pc_q;

  // read goes out with the pc being loaded, data back next cycle
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = {next_pc[PC_WD-1:3], 3'b000}; // word aligned

endmodule

// File: verilog/ysyx_fetch_if_stage.sv
// IF stage completes in one cycle and relies on SRAM data arriving exactly one cycle after ren
module ysyx_fetch_if_stage (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  // from output buffer
  input  logic                            i_buf_allowin,
  // redirect from decode
  input  logic                            i_br_sel,
  // inst sram read data
  input  ysyx_fetch_inst_pkg::sram_word_u i_inst_sram_rdata,
  // from pc generator
  input  ysyx_fetch_cfg_pkg::pc_t         i_pc,
  output logic                            o_pc_load,
  // to output buffer
  output logic                            o_fs_valid,
  output ysyx_fetch_cfg_pkg::pc_t         o_fs_pc,
  output ysyx_fetch_inst_pkg::inst_t      o_fs_inst
);

  import ysyx_fetch_inst_pkg::*;

  logic  fs_valid;
  logic  fs_allowin;
  logic  fs_stall;
  logic  hold_valid;
  inst_t hold_inst;
  inst_t sel_inst;

  assign fs_allowin = !fs_valid || i_buf_allowin;
  assign fs_stall   = fs_valid && !i_buf_allowin;

  // new fetch when the stage drains, or always on a redirect
  assign o_pc_load = i_rst_n && (fs_allowin || i_br_sel);

  // a redirect replaces whatever was in flight with the target fetch
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (o_pc_load) begin
      fs_valid <= 1'b1;
    end
  end

  // pick the 32-bit half by pc[2]
  assign sel_inst = i_pc[2] ? i_inst_sram_rdata.halves.hi
                            : i_inst_sram_rdata.halves.lo;

  // sram data lasts one cycle only, so keep it across a stall
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      hold_valid <= 1'b0;
    end else if (o_pc_load) begin
      hold_valid <= 1'b0; // held inst consumed or flushed
    end else if (fs_stall) begin
      hold_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fs_stall && !hold_valid) begin
      hold_inst <= sel_inst; // first stalled cycle
    end
  end

  assign o_fs_valid = fs_valid;
  assign o_fs_pc    = i_pc;
  assign o_fs_inst  = hold_valid ? hold_inst : sel_inst;

endmodule

// File: verilog/ysyx_fetch_out_buf.sv
// Two-entry buffer only takes input when not full and a flush drops both entries at the clock edge
module ysyx_fetch_out_buf (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_flush,
  // from if stage
  input  logic                       i_valid,
  input  ysyx_fetch_cfg_pkg::pc_t    i_pc,
  input  ysyx_fetch_inst_pkg::inst_t i_inst,
  output logic                       o_allowin,
  // to decode
  input  logic                       i_ds_allowin,
  output logic                       o_ds_valid,
  output ysyx_fetch_cfg_pkg::pc_t    o_ds_pc,
  output ysyx_fetch_inst_pkg::inst_t o_ds_inst
);

  import ysyx_fetch_cfg_pkg::*;
  import ysyx_fetch_inst_pkg::*;

  pc_t        pc_q   [2];
  inst_t      inst_q [2];
  logic       wptr;
  logic       rptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign o_allowin  = (count != 2'd2); // low only when both entries hold data
  assign o_ds_valid = (count != 2'd0);

  assign push = i_valid && o_allowin;
  assign pop  = o_ds_valid && i_ds_allowin;

  // pointers and occupancy
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      wptr  <= 1'b0;
      rptr  <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) begin
        wptr <= ~wptr;
      end
      if (pop) begin
        rptr <= ~rptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count; // idle or pass-through
      endcase
    end
  end

  // entry storage
  always_ff @(posedge i_clk) begin
    if (push) begin
      pc_q[wptr]   <= i_pc;
      inst_q[wptr] <= i_inst;
    end
  end

  // oldest entry faces decode
  assign o_ds_pc   = pc_q[rptr];
  assign o_ds_inst = inst_q[rptr];

endmodule

// File: verilog/ysyx_fetch_top.sv
// Fetch front end assumes a single-cycle redirect pulse and a one-cycle synchronous SRAM outside
module ysyx_fetch_top (
  input  logic                                        i_clk,
  input  logic                                        i_rst_n,
  // redirect from decode
  input  logic                                        i_br_sel,
  input  ysyx_fetch_cfg_pkg::pc_t                     i_br_target,
  // inst sram
  output logic                                        o_inst_sram_ren,
  output logic [ysyx_fetch_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [ysyx_fetch_cfg_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  // to decode
  input  logic                                        i_ds_allowin,
  output logic                                        o_ds_valid,
  output ysyx_fetch_cfg_pkg::pc_t                     o_ds_pc,
  output ysyx_fetch_inst_pkg::inst_t                  o_ds_inst
);

  import ysyx_fetch_cfg_pkg::*;
  import ysyx_fetch_inst_pkg::*;

  logic  pc_load;
  pc_t   gen_pc;
  logic  fs_valid;
  pc_t   fs_pc;
  inst_t fs_inst;
  logic  buf_allowin;

  ysyx_fetch_pc u_pc (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_load           (pc_load),
    .i_br_sel         (i_br_sel),
    .i_br_target      (i_br_target),
    .o_pc             (gen_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  ysyx_fetch_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_buf_allowin     (buf_allowin),
    .i_br_sel          (i_br_sel),         // flushes the in-flight fetch
    .i_inst_sram_rdata (i_inst_sram_rdata), // raw word into the union view
    .i_pc              (gen_pc),
    .o_pc_load         (pc_load),
    .o_fs_valid        (fs_valid),
    .o_fs_pc           (fs_pc),
    .o_fs_inst         (fs_inst)
  );

  ysyx_fetch_out_buf u_out_buf (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flush      (i_br_sel), // younger entries are wrong path
    .i_valid      (fs_valid),
    .i_pc         (fs_pc),
    .i_inst       (fs_inst),
    .o_allowin    (buf_allowin),
    .i_ds_allowin (i_ds_allowin),
    .o_ds_valid   (o_ds_valid),
    .o_ds_pc      (o_ds_pc),
    .o_ds_inst    (o_ds_inst)
  );

endmodule

// File: test/tb_ysyx_fetch.sv
// SRAM model holds address XOR 0xA5A50000 everywhere and decode stalls in a redirect cycle
module tb_ysyx_fetch;

  import ysyx_fetch_cfg_pkg::*;
  import ysyx_fetch_inst_pkg::*;

  localparam int unsigned N_INST = 64; // deliveries per streaming test

  // generous cycle budget per test
  localparam int unsigned LEN_RESET    = 12;
  localparam int unsigned LEN_STREAM   = N_INST + 16;
  localparam int unsigned LEN_RANDOM   = 5 * N_INST;
  localparam int unsigned LEN_REDIR_HI = 30;
  localparam int unsigned LEN_FULL     = 40;
  localparam int unsigned LEN_B2B      = 30;
  localparam int unsigned CYCLE_LIMIT  = LEN_RESET + LEN_STREAM + LEN_RANDOM
                                         + LEN_REDIR_HI + LEN_FULL + LEN_B2B + 200;

  logic                    clk;
  logic                    rst_n;
  logic                    br_sel;
  pc_t                     br_target;
  logic                    ds_allowin;
  logic                    inst_sram_ren;
  logic [SRAM_ADDR_WD-1:0] inst_sram_addr;
  sram_word_u              sram_word;
  logic                    ds_valid;
  pc_t                     ds_pc;
  inst_t                   ds_inst;

  // scoreboard state
  pc_t         exp_pc;
  pc_t         last_pc;
  int unsigned delivered     = 0;
  logic        took          = 1'b0; // handshake seen at the last rising edge
  int unsigned cycle_cnt     = 0;
  int unsigned n_checks      = 0;
  int unsigned n_errors      = 0;
  int unsigned n_tests       = 0;
  int unsigned test_err_base = 0;

  ysyx_fetch_top UUT (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_br_sel          (br_sel),
    .i_br_target       (br_target),
    .o_inst_sram_ren   (inst_sram_ren),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (sram_word.whole),
    .i_ds_allowin      (ds_allowin),
    .o_ds_valid        (ds_valid),
    .o_ds_pc           (ds_pc),
    .o_ds_inst         (ds_inst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory content rule with one instruction per 4-byte address
  function automatic inst_t expected_inst(input pc_t pc);
    return pc[31:0] ^ 32'hA5A5_0000;
  endfunction

  // sram model returns data one cycle after ren
  always @(posedge clk) begin
    if (inst_sram_ren) begin
      check_bit(inst_sram_addr[2:0] == 3'b000, 1'b1, "sram address word aligned");
      sram_word.whole <= {expected_inst(inst_sram_addr + 64'd4),
                          expected_inst(inst_sram_addr)}; // address+4 in the upper half
    end
  end

  task automatic check_pc(input pc_t got, input pc_t exp, input string what);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input inst_t got, input inst_t exp, input string what);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // decode model checks every accepted pair against the expected pc
  always @(posedge clk) begin
    took = rst_n && ds_valid && ds_allowin;
    if (took) begin
      check_pc(ds_pc, exp_pc, "delivered pc");
      check_inst(ds_inst, expected_inst(exp_pc), "delivered inst");
      last_pc   = ds_pc;
      exp_pc    = exp_pc + PC_STEP;
      delivered = delivered + 1;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles, a delivery never came", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic open_test;
    test_err_base = n_errors;
  endtask

  task automatic close_test(input string name);
    n_tests = n_tests + 1;
    if (n_errors == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - test_err_base);
    end
  endtask

  // called and returns at a falling edge
  task automatic wait_deliveries(input int unsigned n);
    int unsigned target;
    target = delivered + n;
    while (delivered < target) begin
      @(negedge clk);
    end
  endtask

  // one-cycle redirect pulse while decode holds
  task automatic issue_redirect(input pc_t target);
    br_sel     = 1'b1;
    br_target  = target;
    ds_allowin = 1'b0;
    exp_pc     = target;
    @(negedge clk);
    br_sel     = 1'b0;
    check_bit(ds_valid, 1'b0, "buffer empty after redirect");
  endtask

  task automatic reset_quiet;
    open_test();
    rst_n      = 1'b0;
    ds_allowin = 1'b1;
    exp_pc     = PC_RESETVAL;
    repeat (8) begin
      @(negedge clk);
      check_bit(ds_valid, 1'b0, "ds_valid during reset");
      check_bit(inst_sram_ren, 1'b0, "sram ren during reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(ds_valid, 1'b0, "ds_valid one cycle after reset");
    @(negedge clk);
    check_bit(ds_valid, 1'b1, "first ds_valid after reset"); // if stage 0 + buffer 1
    close_test("reset");
  endtask

  task automatic stream_in_order;
    open_test();
    ds_allowin = 1'b1;
    wait_deliveries(1);
    check_pc(last_pc, PC_RESETVAL, "first delivered pc");
    repeat (N_INST - 1) begin
      @(negedge clk);
      check_bit(took, 1'b1, "delivery on consecutive cycle");
    end
    close_test("stream");
  endtask

  task automatic random_backpressure;
    int unsigned target;
    open_test();
    target = delivered + N_INST;
    while (delivered < target) begin
      ds_allowin = ($urandom % 2) != 0;
      @(negedge clk);
    end
    ds_allowin = 1'b1;
    close_test("random backpressure");
  endtask

  task automatic redirect_hi_half;
    pc_t target;
    open_test();
    target = 64'h0000_0000_8000_1004; // bit 2 set selects the upper half
    issue_redirect(target);
    ds_allowin = 1'b1;
    wait_deliveries(1);
    check_pc(last_pc, target, "first pc after redirect");
    wait_deliveries(8);
    close_test("redirect hi half");
  endtask

  task automatic redirect_while_full;
    pc_t target;
    open_test();
    target     = 64'h0000_0000_8000_2000;
    ds_allowin = 1'b0;
    repeat (6) begin
      @(negedge clk);
    end
    // both entries full and one more held in the if stage
    check_bit(ds_valid, 1'b1, "buffer holds data while stalled");
    check_bit(inst_sram_ren, 1'b0, "pc holds while stalled");
    issue_redirect(target);
    ds_allowin = 1'b1;
    wait_deliveries(1);
    check_pc(last_pc, target, "first pc after stalled redirect");
    wait_deliveries(8);
    close_test("redirect while full");
  endtask

  task automatic back_to_back_redirect;
    pc_t first_target;
    pc_t second_target;
    open_test();
    first_target  = 64'h0000_0000_8000_3000;
    second_target = 64'h0000_0000_8000_400c;
    issue_redirect(first_target);
    issue_redirect(second_target); // overrides the first one
    ds_allowin = 1'b1;
    wait_deliveries(1);
    check_pc(last_pc, second_target, "first pc after back-to-back redirect");
    wait_deliveries(8);
    close_test("back-to-back redirect");
  endtask

  initial begin
    rst_n           = 1'b0;
    br_sel          = 1'b0;
    br_target       = '0;
    ds_allowin      = 1'b1;
    sram_word.whole = '0;
    exp_pc          = PC_RESETVAL;
    last_pc         = '0;
    void'($urandom(48));

    reset_quiet();
    stream_in_order();
    random_backpressure();
    redirect_hi_half();
    redirect_while_full();
    back_to_back_redirect();

    @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d, delivered %0d",
             n_tests, n_checks, n_errors, delivered);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: ysyx_fetch.f
verilog/ysyx_fetch_cfg_pkg.sv
verilog/ysyx_fetch_inst_pkg.sv
verilog/ysyx_fetch_pc.sv
verilog/ysyx_fetch_if_stage.sv
verilog/ysyx_fetch_out_buf.sv
verilog/ysyx_fetch_top.sv
test/tb_ysyx_fetch.sv

// File: Bender.yml
package:
  name: ysyx_fetch

sources:
  # packages come before the modules that import them
  - verilog/ysyx_fetch_cfg_pkg.sv
  - verilog/ysyx_fetch_inst_pkg.sv
  # fetch front end
  - verilog/ysyx_fetch_pc.sv
  - verilog/ysyx_fetch_if_stage.sv
  - verilog/ysyx_fetch_out_buf.sv
  - verilog/ysyx_fetch_top.sv
  # directed testbench
  - target: simulation
    files:
      - test/tb_ysyx_fetch.sv
